//--- design/dma_seq_pkg.sv
// ----------------------------------------------------------
// Shared types and constants for the DMA sequencer.
// Holds the descriptor and channel structs, the engine
// register map, the transfer opcodes and the element sizes.
// ----------------------------------------------------------
`default_nettype none

package dma_seq_pkg;

    // transfer kinds
    typedef enum logic [1:0] {
        bring_a,
        bring_b,
        bring_c,
        send_c
    } xfer_op_e;

    // engine register offsets
    typedef enum logic [5:0] {
        reg_control     = 6'h00,
        reg_irq_mask    = 6'h04,
        reg_irq_status  = 6'h0C,
        reg_reader_addr = 6'h10,
        reg_writer_addr = 6'h20,
        reg_btt         = 6'h30
    } dma_reg_e;

    // bytes per element of each operand
    localparam logic [31:0] a_bytes = 32'd1;
    localparam logic [31:0] b_bytes = 32'd1;
    localparam logic [31:0] c_bytes = 32'd4;

    // bit 0 reader, bit 1 writer
    localparam logic [1:0] irq_both = 2'd3;

    typedef struct packed {
        xfer_op_e    op;
        logic [31:0] dram_base;
        logic [15:0] ett;
        logic [15:0] y_step;
        logic [15:0] z_step;
        logic [15:0] y_lim;
        logic [15:0] z_lim;
    } xfer_desc_t;

    typedef struct packed {
        logic [31:0] dram_elem_off;
        logic [31:0] sram_off;
    } walk_pos_t;

    typedef struct packed {
        logic [31:0] btt;
        logic [31:0] reader_addr;
        logic [31:0] writer_addr;
    } chunk_addr_t;

    typedef struct packed {
        logic        valid;
        dma_reg_e    addr;
        logic [31:0] data;
    } wr_cmd_t;

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } axil_wr_rsp_t;

    // send_c moves psums, so it shares the C size
    function automatic logic [31:0] elem_bytes(xfer_op_e op);
        logic [31:0] size;
        case (op)
            bring_a: size = a_bytes;
            bring_b: size = b_bytes;
            default: size = c_bytes;
        endcase
        return size;
    endfunction

endpackage

`default_nettype wire

//--- design/dma_chunk_walker.sv
// ----------------------------------------------------------
// Two-level chunk walker. y is the inner level and z the
// outer one; tracks the DRAM element offset of the current
// chunk and the running byte offset into local SRAM.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_chunk_walker (
    input  logic                    clk,
    input  logic                    rst,
    input  dma_seq_pkg::xfer_desc_t desc_q,
    input  logic                    walk_clear,
    input  logic                    walk_step,
    output dma_seq_pkg::walk_pos_t  pos,
    output logic                    last_chunk
);

    logic [15:0] y_idx;
    logic [15:0] z_idx;
    logic [31:0] y_off;
    logic [31:0] z_off;
    logic [31:0] sram_off_q;
    logic [31:0] chunk_bytes;

    assign chunk_bytes = {16'd0, desc_q.ett} * dma_seq_pkg::elem_bytes(desc_q.op);

    always_ff @(posedge clk) begin
        if (rst || walk_clear) begin
            y_idx      <= '0;
            z_idx      <= '0;
            y_off      <= '0;
            z_off      <= '0;
            sram_off_q <= '0;
        end else if (walk_step) begin
            if (y_idx == desc_q.y_lim) begin
                y_idx <= '0;
                y_off <= '0;
                if (z_idx == desc_q.z_lim) begin
                    z_idx      <= '0;
                    z_off      <= '0;
                    sram_off_q <= '0;
                end else begin
                    z_idx      <= z_idx + 16'd1;
                    z_off      <= z_off + {16'd0, desc_q.z_step};
                    sram_off_q <= sram_off_q + chunk_bytes;
                end
            end else begin
                y_idx      <= y_idx + 16'd1;
                y_off      <= y_off + {16'd0, desc_q.y_step};
                sram_off_q <= sram_off_q + chunk_bytes;
            end
        end
    end

    assign pos = '{dram_elem_off: y_off + z_off, sram_off: sram_off_q};

    assign last_chunk = (y_idx == desc_q.y_lim) && (z_idx == desc_q.z_lim);

endmodule

`default_nettype wire

//--- design/dma_addr_gen.sv
// ----------------------------------------------------------
// Registered address generator. Turns the descriptor and
// walker position into btt and the reader and writer
// addresses of the current chunk, one cycle later.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_addr_gen #(
    parameter logic [31:0] sram_a_base = 32'h0001_0000,
    parameter logic [31:0] sram_b_base = 32'h0002_0000,
    parameter logic [31:0] sram_c_base = 32'h0003_0000
) (
    input  logic                     clk,
    input  dma_seq_pkg::xfer_desc_t  desc_q,
    input  dma_seq_pkg::walk_pos_t   pos,
    output dma_seq_pkg::chunk_addr_t addr
);

    logic [31:0] esize;
    logic [31:0] dram_addr;
    logic [31:0] sram_base;
    logic [31:0] sram_addr;

    assign esize     = dma_seq_pkg::elem_bytes(desc_q.op);
    assign dram_addr = desc_q.dram_base + pos.dram_elem_off * esize;

    // C window serves both directions
    always_comb begin
        case (desc_q.op)
            dma_seq_pkg::bring_a: sram_base = sram_a_base;
            dma_seq_pkg::bring_b: sram_base = sram_b_base;
            default:              sram_base = sram_c_base;
        endcase
    end

    assign sram_addr = sram_base + pos.sram_off;

    always_ff @(posedge clk) begin
        addr.btt <= {16'd0, desc_q.ett} * esize;
        if (desc_q.op == dma_seq_pkg::send_c) begin
            addr.reader_addr <= sram_addr;
            addr.writer_addr <= dram_addr;
        end else begin
            addr.reader_addr <= dram_addr;
            addr.writer_addr <= sram_addr;
        end
    end

endmodule

`default_nettype wire

//--- design/dma_reg_writer.sv
// ----------------------------------------------------------
// Single register write on the engine's AXI-Lite write
// channel. Takes a one-cycle command, runs address, data
// and response phases in turn, pulses wr_done on bvalid.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_reg_writer (
    input  logic                      clk,
    input  logic                      rst,
    input  dma_seq_pkg::wr_cmd_t      wr_cmd,
    output dma_seq_pkg::axil_wr_req_t dma_wr,
    input  dma_seq_pkg::axil_wr_rsp_t dma_wr_rsp,
    output logic                      wr_done
);

    typedef enum logic [1:0] {
        w_idle,
        w_addr,
        w_data,
        w_resp
    } wr_state_e;

    wr_state_e             state_q;
    dma_seq_pkg::dma_reg_e addr_q;
    logic [31:0]           data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= w_idle;
        end else begin
            case (state_q)
                w_idle: if (wr_cmd.valid) state_q <= w_addr;
                // data phase only after the address is taken
                w_addr: if (dma_wr_rsp.awready) state_q <= w_data;
                w_data: if (dma_wr_rsp.wready) state_q <= w_resp;
                w_resp: if (dma_wr_rsp.bvalid) state_q <= w_idle;
                default: state_q <= w_idle;
            endcase
        end
    end

    // address and data stay stable until the write retires
    always_ff @(posedge clk) begin
        if ((state_q == w_idle) && wr_cmd.valid) begin
            addr_q <= wr_cmd.addr;
            data_q <= wr_cmd.data;
        end
    end

    always_comb begin
        dma_wr.awvalid = (state_q == w_addr);
        dma_wr.awaddr  = {26'd0, addr_q};
        dma_wr.wvalid  = (state_q == w_data);
        dma_wr.wdata   = data_q;
        dma_wr.wstrb   = 4'hF;
        dma_wr.bready  = (state_q == w_resp);
    end

    assign wr_done = (state_q == w_resp) && dma_wr_rsp.bvalid;

endmodule

`default_nettype wire

//--- design/dma_ctrl_fsm.sv
// ----------------------------------------------------------
// Control FSM of the DMA sequencer. Latches a descriptor on
// start, writes the irq mask once, then per chunk programs
// btt, reader and writer address and control, waits for
// both engine irqs and clears them before stepping on.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  dma_seq_pkg::xfer_desc_t  desc,
    input  logic                     reader_irq,
    input  logic                     writer_irq,
    input  logic                     last_chunk,
    input  dma_seq_pkg::chunk_addr_t addr,
    input  logic                     wr_done,
    output dma_seq_pkg::wr_cmd_t     wr_cmd,
    output dma_seq_pkg::xfer_desc_t  desc_q,
    output logic                     walk_clear,
    output logic                     walk_step,
    output logic                     busy,
    output logic                     done
);

    typedef enum logic [3:0] {
        st_idle,
        st_settle,
        st_wr_mask,
        st_wr_btt,
        st_wr_reader,
        st_wr_writer,
        st_wr_ctrl,
        st_wait_rd_irq,
        st_wait_wr_irq,
        st_wr_clear,
        st_next
    } ctrl_state_e;

    ctrl_state_e state_q;
    logic        issued_q;
    logic        is_write;

    assign is_write = (state_q == st_wr_mask)   || (state_q == st_wr_btt)    ||
                      (state_q == st_wr_reader) || (state_q == st_wr_writer) ||
                      (state_q == st_wr_ctrl)   || (state_q == st_wr_clear);

    // one command per write state, in its first cycle
    always_comb begin
        wr_cmd.valid = is_write && !issued_q;
        wr_cmd.addr  = dma_seq_pkg::reg_control;
        wr_cmd.data  = {30'd0, dma_seq_pkg::irq_both};
        case (state_q)
            st_wr_mask:   wr_cmd.addr = dma_seq_pkg::reg_irq_mask;
            st_wr_btt: begin
                wr_cmd.addr = dma_seq_pkg::reg_btt;
                wr_cmd.data = addr.btt;
            end
            st_wr_reader: begin
                wr_cmd.addr = dma_seq_pkg::reg_reader_addr;
                wr_cmd.data = addr.reader_addr;
            end
            st_wr_writer: begin
                wr_cmd.addr = dma_seq_pkg::reg_writer_addr;
                wr_cmd.data = addr.writer_addr;
            end
            st_wr_clear:  wr_cmd.addr = dma_seq_pkg::reg_irq_status;
            default:      wr_cmd.addr = dma_seq_pkg::reg_control;
        endcase
    end

    assign busy      = (state_q != st_idle);
    assign done      = (state_q == st_next) && last_chunk;
    assign walk_step = (state_q == st_next) && !last_chunk;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= st_idle;
            issued_q   <= 1'b0;
            walk_clear <= 1'b0;
        end else begin
            walk_clear <= 1'b0;
            if (is_write) begin
                if (wr_done) begin
                    issued_q <= 1'b0;
                end else if (!issued_q) begin
                    issued_q <= 1'b1;
                end
            end
            case (state_q)
                st_idle: begin
                    if (start) begin
                        walk_clear <= 1'b1;
                        state_q    <= st_wr_mask;
                    end
                end
                // walker and address pipeline catch up here
                st_settle:    state_q <= st_wr_btt;
                st_wr_mask:   if (wr_done) state_q <= st_wr_btt;
                st_wr_btt:    if (wr_done) state_q <= st_wr_reader;
                st_wr_reader: if (wr_done) state_q <= st_wr_writer;
                st_wr_writer: if (wr_done) state_q <= st_wr_ctrl;
                st_wr_ctrl:   if (wr_done) state_q <= st_wait_rd_irq;
                st_wait_rd_irq: if (reader_irq) state_q <= st_wait_wr_irq;
                st_wait_wr_irq: if (writer_irq) state_q <= st_wr_clear;
                st_wr_clear:  if (wr_done) state_q <= st_next;
                st_next:      state_q <= last_chunk ? st_idle : st_settle;
                default:      state_q <= st_idle;
            endcase
        end
    end

    // descriptor held for the whole transfer
    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && start) begin
            desc_q <= desc;
        end
    end

endmodule

`default_nettype wire

//--- design/dma_seq_top.sv
// ----------------------------------------------------------
// DMA sequencer top level. Connects the control FSM, chunk
// walker, address generator and register writer, and sets
// the local SRAM windows in the engine's address map.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_seq_top #(
    parameter logic [31:0] sram_a_base = 32'h0001_0000,
    parameter logic [31:0] sram_b_base = 32'h0002_0000,
    parameter logic [31:0] sram_c_base = 32'h0003_0000
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  dma_seq_pkg::xfer_desc_t   desc,
    input  logic                      reader_irq,
    input  logic                      writer_irq,
    output dma_seq_pkg::axil_wr_req_t dma_wr,
    input  dma_seq_pkg::axil_wr_rsp_t dma_wr_rsp,
    output logic                      busy,
    output logic                      done
);

    dma_seq_pkg::xfer_desc_t  desc_q;
    dma_seq_pkg::walk_pos_t   pos;
    dma_seq_pkg::chunk_addr_t addr;
    dma_seq_pkg::wr_cmd_t     wr_cmd;
    logic                     walk_clear;
    logic                     walk_step;
    logic                     last_chunk;
    logic                     wr_done;

    dma_ctrl_fsm u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .desc       (desc),
        .reader_irq (reader_irq),
        .writer_irq (writer_irq),
        .last_chunk (last_chunk),
        .addr       (addr),
        .wr_done    (wr_done),
        .wr_cmd     (wr_cmd),
        .desc_q     (desc_q),
        .walk_clear (walk_clear),
        .walk_step  (walk_step),
        .busy       (busy),
        .done       (done)
    );

    dma_chunk_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .desc_q     (desc_q),
        .walk_clear (walk_clear),
        .walk_step  (walk_step),
        .pos        (pos),
        .last_chunk (last_chunk)
    );

    dma_addr_gen #(
        .sram_a_base (sram_a_base),
        .sram_b_base (sram_b_base),
        .sram_c_base (sram_c_base)
    ) u_addr_gen (
        .clk    (clk),
        .desc_q (desc_q),
        .pos    (pos),
        .addr   (addr)
    );

    dma_reg_writer u_writer (
        .clk        (clk),
        .rst        (rst),
        .wr_cmd     (wr_cmd),
        .dma_wr     (dma_wr),
        .dma_wr_rsp (dma_wr_rsp),
        .wr_done    (wr_done)
    );

endmodule

`default_nettype wire

//--- sim/dma_seq_chk.sv
// ------------------------------------------------------------
// Protocol checks bound into the DMA sequencer top level.
// Watches write channel stability and the status outputs.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_seq_chk (
    input logic                      clk,
    input logic                      rst,
    input dma_seq_pkg::axil_wr_req_t dma_wr,
    input dma_seq_pkg::axil_wr_rsp_t dma_wr_rsp,
    input logic                      busy,
    input logic                      done
);

    // address held until accepted
    aw_stable: assert property (@(posedge clk) disable iff (rst)
        dma_wr.awvalid && !dma_wr_rsp.awready |=> dma_wr.awvalid && $stable(dma_wr.awaddr))
        else $error("awaddr changed or awvalid dropped before awready");

    w_stable: assert property (@(posedge clk) disable iff (rst)
        dma_wr.wvalid && !dma_wr_rsp.wready |=> dma_wr.wvalid && $stable(dma_wr.wdata))
        else $error("wdata changed or wvalid dropped before wready");

    // data phase opens only in the cycle after the address is taken
    w_after_aw: assert property (@(posedge clk) disable iff (rst)
        $rose(dma_wr.wvalid) |-> $past(dma_wr.awvalid && dma_wr_rsp.awready))
        else $error("wvalid raised while the address was not yet accepted");

    // busy covers the done cycle and drops right after it
    done_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy ##1 !busy)
        else $error("done pulsed outside busy or busy stayed high after done");

endmodule

bind dma_seq_top dma_seq_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .dma_wr     (dma_wr),
    .dma_wr_rsp (dma_wr_rsp),
    .busy       (busy),
    .done       (done)
);

`default_nettype wire

//--- sim/dma_seq_tb.sv
// ------------------------------------------------------------
// Testbench for the DMA sequencer. Models the DMA engine's
// write channel and irqs, applies a table of descriptors and
// compares every logged register write with expected values.
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_seq_tb;

    localparam int num_rows = 6;

    logic                      clk;
    logic                      rst;
    logic                      start;
    dma_seq_pkg::xfer_desc_t   desc;
    logic                      reader_irq;
    logic                      writer_irq;
    dma_seq_pkg::axil_wr_req_t dma_wr;
    dma_seq_pkg::axil_wr_rsp_t rsp;
    logic                      busy;
    logic                      done;

    logic [31:0] lfsr_q = 32'hc77c;
    logic [63:0] log_q[$];
    logic [63:0] exp_q[$];
    int          done_cnt;

    dma_seq_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .desc       (desc),
        .reader_irq (reader_irq),
        .writer_irq (writer_irq),
        .dma_wr     (dma_wr),
        .dma_wr_rsp (rsp),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // columns: op, dram_base, ett, y_step, z_step, y_lim, z_lim
    function automatic dma_seq_pkg::xfer_desc_t table_row(int idx);
        dma_seq_pkg::xfer_desc_t d;
        case (idx)
            0: d = '{dma_seq_pkg::bring_a, 32'h8000_0000, 16'd64, 16'd0, 16'd0, 16'd0, 16'd0};
            1: d = '{dma_seq_pkg::bring_b, 32'h8010_0000, 16'd32, 16'd128, 16'd0, 16'd3, 16'd0};
            2: d = '{dma_seq_pkg::bring_c, 32'h8020_0000, 16'd16, 16'd64, 16'd1024, 16'd2, 16'd1};
            3: d = '{dma_seq_pkg::send_c, 32'h8020_0000, 16'd16, 16'd64, 16'd1024, 16'd2, 16'd1};
            4: d = '{dma_seq_pkg::bring_a, 32'h8030_0000, 16'd8, 16'd16, 16'd256, 16'd1, 16'd2};
            default: d = '{dma_seq_pkg::send_c, 32'h8040_0000, 16'd4, 16'd0, 16'd0, 16'd0, 16'd0};
        endcase
        return d;
    endfunction

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [1:0] draw_delay();
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            lfsr_q  = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            bits[i] = lfsr_q[0];
        end
        return bits;
    endfunction

    function automatic logic [31:0] reg_word(dma_seq_pkg::dma_reg_e r);
        return {26'd0, r};
    endfunction

    function automatic logic [31:0] op_size(dma_seq_pkg::xfer_op_e op);
        case (op)
            dma_seq_pkg::bring_a: return dma_seq_pkg::a_bytes;
            dma_seq_pkg::bring_b: return dma_seq_pkg::b_bytes;
            default:              return dma_seq_pkg::c_bytes;
        endcase
    endfunction

    function automatic logic [31:0] op_window(dma_seq_pkg::xfer_op_e op);
        case (op)
            dma_seq_pkg::bring_a: return u_dut.sram_a_base;
            dma_seq_pkg::bring_b: return u_dut.sram_b_base;
            default:              return u_dut.sram_c_base;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic idle_cycles(input logic [1:0] n);
        repeat (n) @(posedge clk);
    endtask

    // mask write, then five writes per chunk with y as the inner level
    task automatic build_expected(input dma_seq_pkg::xfer_desc_t d);
        logic [31:0] esize;
        logic [31:0] btt;
        logic [31:0] dram;
        logic [31:0] sram;
        logic [31:0] both;
        int unsigned chunk;
        exp_q.delete();
        esize = op_size(d.op);
        btt   = {16'd0, d.ett} * esize;
        both  = {30'd0, dma_seq_pkg::irq_both};
        chunk = 0;
        exp_q.push_back({reg_word(dma_seq_pkg::reg_irq_mask), both});
        for (int unsigned z = 0; z <= {16'd0, d.z_lim}; z++) begin
            for (int unsigned y = 0; y <= {16'd0, d.y_lim}; y++) begin
                dram = d.dram_base + (y * {16'd0, d.y_step} + z * {16'd0, d.z_step}) * esize;
                sram = op_window(d.op) + chunk * btt;
                exp_q.push_back({reg_word(dma_seq_pkg::reg_btt), btt});
                if (d.op == dma_seq_pkg::send_c) begin
                    exp_q.push_back({reg_word(dma_seq_pkg::reg_reader_addr), sram});
                    exp_q.push_back({reg_word(dma_seq_pkg::reg_writer_addr), dram});
                end else begin
                    exp_q.push_back({reg_word(dma_seq_pkg::reg_reader_addr), dram});
                    exp_q.push_back({reg_word(dma_seq_pkg::reg_writer_addr), sram});
                end
                exp_q.push_back({reg_word(dma_seq_pkg::reg_control), both});
                exp_q.push_back({reg_word(dma_seq_pkg::reg_irq_status), both});
                chunk++;
            end
        end
    endtask

    // engine model, one write at a time with random ready delays
    initial begin : engine
        logic [31:0] waddr;
        logic [31:0] wdata;
        rsp        = '0;
        reader_irq = 1'b0;
        writer_irq = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && dma_wr.awvalid) begin
                waddr = dma_wr.awaddr;
                idle_cycles(draw_delay());
                @(posedge clk);
                rsp.awready <= 1'b1;
                @(posedge clk);
                rsp.awready <= 1'b0;
                idle_cycles(draw_delay());
                @(posedge clk);
                rsp.wready <= 1'b1;
                // data and strobes as seen in the accepting cycle
                @(negedge clk);
                wdata = dma_wr.wdata;
                assert (dma_wr.wvalid && dma_wr.wstrb == 4'hF)
                else report_failure($sformatf("ERR %0t: wready cycle saw wvalid %0b, wstrb %h",
                                              $time, dma_wr.wvalid, dma_wr.wstrb));
                @(posedge clk);
                rsp.wready <= 1'b0;
                idle_cycles(draw_delay());
                @(posedge clk);
                rsp.bvalid <= 1'b1;
                @(negedge clk);
                assert (dma_wr.bready)
                else report_failure($sformatf("ERR %0t: bready low in the bvalid cycle", $time));
                @(posedge clk);
                rsp.bvalid <= 1'b0;
                log_q.push_back({waddr, wdata});
                if (waddr == reg_word(dma_seq_pkg::reg_irq_status)) begin
                    assert (reader_irq && writer_irq)
                    else report_failure("status clear was written before both irqs were raised");
                    reader_irq <= 1'b0;
                    writer_irq <= 1'b0;
                end
                // engine finishes reading, then writing
                if (waddr == reg_word(dma_seq_pkg::reg_control)) begin
                    idle_cycles(draw_delay());
                    @(posedge clk);
                    reader_irq <= 1'b1;
                    idle_cycles(draw_delay());
                    @(posedge clk);
                    writer_irq <= 1'b1;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && done) begin
            done_cnt++;
        end
    end

    initial begin : watchdog
        int unsigned             total;
        dma_seq_pkg::xfer_desc_t d;
        total = 0;
        for (int r = 0; r < num_rows; r++) begin
            d = table_row(r);
            total += 1 + 5 * ({16'd0, d.y_lim} + 1) * ({16'd0, d.z_lim} + 1);
        end
        repeat (total * 200) @(posedge clk);
        report_failure($sformatf("timeout, transfers did not finish within %0d cycles",
                                 total * 200));
    end

    initial begin : main
        dma_seq_pkg::xfer_desc_t d;
        rst      = 1'b1;
        start    = 1'b0;
        desc     = '0;
        done_cnt = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            d = table_row(r);
            build_expected(d);
            log_q.delete();
            done_cnt = 0;
            @(posedge clk);
            start <= 1'b1;
            desc  <= d;
            @(posedge clk);
            start <= 1'b0;
            // second start while busy, must add nothing
            repeat (3) @(posedge clk);
            start <= 1'b1;
            desc  <= table_row((r + 1) % num_rows);
            @(posedge clk);
            start <= 1'b0;
            while (done_cnt == 0) @(negedge clk);
            @(negedge clk);
            assert (done_cnt == 1 && !busy)
            else report_failure($sformatf("ERR %0t: row %0d done count %0d, busy %0b after done",
                                          $time, r, done_cnt, busy));
            assert (log_q.size() == exp_q.size())
            else report_failure($sformatf("ERR %0t: row %0d logged %0d writes, expected %0d",
                                          $time, r, log_q.size(), exp_q.size()));
            for (int i = 0; i < exp_q.size(); i++) begin
                assert (log_q[i] == exp_q[i])
                else report_failure($sformatf("ERR %0t: row %0d write %0d got %h/%h, exp %h/%h",
                                              $time, r, i, log_q[i][63:32], log_q[i][31:0],
                                              exp_q[i][63:32], exp_q[i][31:0]));
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
design/dma_seq_pkg.sv
design/dma_chunk_walker.sv
design/dma_addr_gen.sv
design/dma_reg_writer.sv
design/dma_ctrl_fsm.sv
design/dma_seq_top.sv
sim/dma_seq_chk.sv
sim/dma_seq_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := dma_seq_tb
FILELIST  := filelist.f
BUILD     := obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
